// ==== src/noc_nif_pkg.sv ====
// ==========================================================
// Shared widths, counts and enums of the NoC tile network
// interface. Imported by every RTL block and the testbench,
// always through a wildcard import in the module header.
// Flit layout is {type[1:0], payload[31:0]}.
// ==========================================================
package noc_nif_pkg;

  // payload carried by one flit
  localparam int FlitDataWidth = 32;

  // type bits sit on top of the payload
  localparam int FlitTypeWidth = 2;

  // full flit on the router link
  localparam int FlitWidth = FlitDataWidth + FlitTypeWidth;

  // virtual channels, one framer each
  localparam int NumVc = 2;

  localparam int VcIdWidth = 1; // enough for NumVc ids

  // packet size counts flits after the head, 1 to 15
  localparam int PktSzWidth = 4;

  // flit type stamped into the two top flit bits
  typedef enum logic [FlitTypeWidth-1:0] {
    HEAD_FLIT = 2'b00, // opens a packet
    BODY_FLIT = 2'b01, // middle of a packet
    TAIL_FLIT = 2'b10  // closes a packet
  } flit_type_t;

  // per-VC receive tracking in the deframer
  typedef enum logic {
    RX_IDLE   = 1'b0, // waiting for a head
    RX_IN_PKT = 1'b1  // head seen, tail pending
  } rx_state_t;

endpackage

// ==== src/flit_link_if.sv ====
// ==========================================================
// Flit link between a VC framer and the link arbiter.
// valid/ready handshake, a flit moves on a clock edge where
// both are high. vc_tag is a static strap set by the top to
// tell the framer which VC id it drives.
// ==========================================================
`timescale 1ns/1ns

interface flit_link_if
  import noc_nif_pkg::*;
();

  logic                 valid;  // flit offered
  logic                 ready;  // flit taken
  logic [VcIdWidth-1:0] vc_id;  // owning virtual channel
  logic [FlitWidth-1:0] fdata;  // type bits + payload
  logic [VcIdWidth-1:0] vc_tag; // vc index strap from the top

  // flit producer side
  modport send (
    output valid, vc_id, fdata,
    input  ready, vc_tag
  );

  // flit consumer side
  modport recv (
    input  valid, vc_id, fdata,
    output ready
  );

endinterface

// ==== src/pkt_framer.sv ====
// ==========================================================
// Per-VC transmit framer. Takes 32-bit payload words with a
// packet size and stamps HEAD/BODY/TAIL into the top flit
// bits. Payload to link is combinational, the flit counter
// moves on each accepted flit. A packet is pkt_sz + 1 flits.
// ==========================================================
`timescale 1ns/1ns

module pkt_framer
  import noc_nif_pkg::*;
(
  input  logic                     clk_axi,
  input  logic                     arst_axi,

  input  logic                     pld_valid_i,
  input  logic [FlitDataWidth-1:0] pld_data_i,
  input  logic [PktSzWidth-1:0]    pld_sz_i,
  output logic                     pld_ready_o,

  flit_link_if.send                link_o
);

  logic                  in_pkt_ff, next_in_pkt; // head already sent
  logic [PktSzWidth-1:0] cnt_ff, next_cnt;       // flits left before tail
  flit_type_t            ftype;
  logic                  xfer;

  // type of the flit currently on offer
  always_comb begin : type_sel
    if (!in_pkt_ff) begin
      ftype = HEAD_FLIT;
    end
    else if (cnt_ff != '0) begin
      ftype = BODY_FLIT;
    end
    else begin
      ftype = TAIL_FLIT;
    end
  end

  always_comb begin : to_link
    link_o.valid = pld_valid_i;
    link_o.vc_id = link_o.vc_tag; // fixed per instance
    link_o.fdata = '0;            // idle link carries zeros
    if (pld_valid_i) begin
      link_o.fdata = {ftype, pld_data_i};
    end
    pld_ready_o  = link_o.ready;  // stalls pass straight back
  end

  assign xfer = pld_valid_i && link_o.ready;

  always_comb begin : cnt_next
    next_in_pkt = in_pkt_ff;
    next_cnt    = cnt_ff;
    if (xfer) begin
      if (!in_pkt_ff) begin
        if (pld_sz_i != '0) begin     // size sampled with the head
          next_in_pkt = 1'b1;
          next_cnt    = pld_sz_i - 1'b1;
        end
      end
      else if (cnt_ff != '0) begin
        next_cnt = cnt_ff - 1'b1;     // body flit gone
      end
      else begin
        next_in_pkt = 1'b0;           // tail gone
      end
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      in_pkt_ff <= 1'b0;
      cnt_ff    <= '0;
    end
    else begin
      in_pkt_ff <= next_in_pkt;
      cnt_ff    <= next_cnt;
    end
  end

endmodule

// ==== src/vc_link_arbiter.sv ====
// ==========================================================
// Wormhole arbiter merging the per-VC framer links onto the
// single local send link. Round-robin pick when unlocked,
// grant held from accepted HEAD to accepted TAIL. Grant and
// data mux are combinational, only the winner sees ready.
// ==========================================================
`timescale 1ns/1ns

module vc_link_arbiter
  import noc_nif_pkg::*;
(
  input  logic      clk_axi,
  input  logic      arst_axi,

  flit_link_if.recv req_i [NumVc],
  flit_link_if.send link_o
);

  logic [NumVc-1:0]     req_valid;
  logic [VcIdWidth-1:0] req_vc    [NumVc];
  logic [FlitWidth-1:0] req_fdata [NumVc];

  logic                 lock_ff;   // packet in flight
  logic [VcIdWidth-1:0] grant_ff;  // vc holding the link
  logic [VcIdWidth-1:0] rr_ptr_ff; // first vc to look at
  logic [VcIdWidth-1:0] pick_vc;
  logic [VcIdWidth-1:0] grant;
  flit_type_t           ftype;
  logic                 xfer;

  // flatten the interface array, constant indices only
  for (genvar g = 0; g < NumVc; g++) begin : g_req
    assign req_valid[g]   = req_i[g].valid;
    assign req_vc[g]      = req_i[g].vc_id;
    assign req_fdata[g]   = req_i[g].fdata;
    assign req_i[g].ready = link_o.ready && (grant == VcIdWidth'(g));
  end

  // first valid vc at or after the pointer
  always_comb begin : rr_pick
    int unsigned idx;
    pick_vc = rr_ptr_ff;
    for (int i = NumVc - 1; i >= 0; i--) begin // lowest offset wins
      idx = (int'(rr_ptr_ff) + i) % NumVc;
      if (req_valid[idx]) begin
        pick_vc = VcIdWidth'(idx);
      end
    end
  end

  assign grant = lock_ff ? grant_ff : pick_vc;

  always_comb begin : to_link
    link_o.valid = req_valid[grant];
    link_o.vc_id = req_vc[grant];
    link_o.fdata = req_fdata[grant];
  end

  assign ftype = flit_type_t'(link_o.fdata[FlitWidth-1 -: FlitTypeWidth]);
  assign xfer  = link_o.valid && link_o.ready;

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      lock_ff   <= 1'b0;
      grant_ff  <= '0;
      rr_ptr_ff <= '0;
    end
    else if (xfer) begin
      if (ftype == HEAD_FLIT) begin
        lock_ff  <= 1'b1;    // hold until tail
        grant_ff <= grant;
      end
      else if (ftype == TAIL_FLIT) begin
        lock_ff   <= 1'b0;
        rr_ptr_ff <= (int'(grant) == NumVc - 1) ? '0 : grant + VcIdWidth'(1);
      end
    end
  end

endmodule

// ==== src/pkt_deframer.sv ====
// ==========================================================
// Receive path from the router local port. Strips the flit
// type, forwards payload and VC id with zero latency, marks
// tails and checks HEAD/BODY/TAIL order per VC. A violation
// gives a one-cycle frame_err_o after the flit transfers.
// ==========================================================
`timescale 1ns/1ns

module pkt_deframer
  import noc_nif_pkg::*;
(
  input  logic                     clk_axi,
  input  logic                     arst_axi,

  input  logic                     recv_valid_i,
  input  logic [VcIdWidth-1:0]     recv_vc_i,
  input  logic [FlitWidth-1:0]     recv_flit_i,
  output logic                     recv_ready_o,

  output logic                     rx_valid_o,
  output logic [VcIdWidth-1:0]     rx_vc_o,
  output logic [FlitDataWidth-1:0] rx_data_o,
  output logic                     rx_last_o,
  input  logic                     rx_ready_i,

  output logic                     frame_err_o
);

  rx_state_t  rx_state_ff [NumVc]; // one tracker per vc
  rx_state_t  next_state;
  flit_type_t ftype;
  logic       bad_flit, xfer, err_ff;

  assign ftype        = flit_type_t'(recv_flit_i[FlitWidth-1 -: FlitTypeWidth]);
  assign rx_valid_o   = recv_valid_i;
  assign rx_vc_o      = recv_vc_i;
  assign rx_data_o    = recv_flit_i[FlitDataWidth-1:0]; // type stripped
  assign rx_last_o    = recv_valid_i && (ftype == TAIL_FLIT);
  assign recv_ready_o = rx_ready_i;
  assign xfer         = recv_valid_i && rx_ready_i;
  assign frame_err_o  = err_ff;

  // order check, next state follows the flit either way
  always_comb begin : order_chk
    case (ftype)
      HEAD_FLIT: begin
        bad_flit   = (rx_state_ff[recv_vc_i] == RX_IN_PKT);
        next_state = RX_IN_PKT;
      end
      BODY_FLIT: begin
        bad_flit   = (rx_state_ff[recv_vc_i] == RX_IDLE);
        next_state = RX_IN_PKT;
      end
      TAIL_FLIT: begin
        bad_flit   = (rx_state_ff[recv_vc_i] == RX_IDLE);
        next_state = RX_IDLE;
      end
      default: begin // unused encoding
        bad_flit   = 1'b1;
        next_state = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      err_ff <= 1'b0;
      for (int v = 0; v < NumVc; v++) begin
        rx_state_ff[v] <= RX_IDLE;
      end
    end
    else begin
      err_ff <= xfer && bad_flit; // single pulse
      if (xfer) begin
        rx_state_ff[recv_vc_i] <= next_state;
      end
    end
  end

endmodule

// ==== src/noc_nif_top.sv ====
// ==========================================================
// NoC tile network interface top. Per-VC framers feed the
// wormhole arbiter which drives the router send link, and
// the deframer turns router flits into typed-free payload.
// All external groups are plain valid/ready ports.
// ==========================================================
`timescale 1ns/1ns

module noc_nif_top
  import noc_nif_pkg::*;
(
  input  logic                                clk_axi,
  input  logic                                arst_axi,

  // payload from the axi slave queues
  input  logic [NumVc-1:0]                    tx_valid_i,
  input  logic [NumVc-1:0][FlitDataWidth-1:0] tx_data_i,
  input  logic [NumVc-1:0][PktSzWidth-1:0]    tx_pkt_sz_i,
  output logic [NumVc-1:0]                    tx_ready_o,

  // router local input
  output logic                                send_valid_o,
  output logic [VcIdWidth-1:0]                send_vc_o,
  output logic [FlitWidth-1:0]                send_flit_o,
  input  logic                                send_ready_i,

  // router local output
  input  logic                                recv_valid_i,
  input  logic [VcIdWidth-1:0]                recv_vc_i,
  input  logic [FlitWidth-1:0]                recv_flit_i,
  output logic                                recv_ready_o,

  // payload to the axi slave rx buffer
  output logic                                rx_valid_o,
  output logic [VcIdWidth-1:0]                rx_vc_o,
  output logic [FlitDataWidth-1:0]            rx_data_o,
  output logic                                rx_last_o,
  input  logic                                rx_ready_i,
  output logic                                frame_err_o
);

  flit_link_if vc_link [NumVc] (); // framer to arbiter
  flit_link_if send_link ();        // arbiter to router

  for (genvar v = 0; v < NumVc; v++) begin : g_vc
    assign vc_link[v].vc_tag = VcIdWidth'(v); // framer vc id

    pkt_framer u_framer (
      .clk_axi     (clk_axi),
      .arst_axi    (arst_axi),
      .pld_valid_i (tx_valid_i[v]),
      .pld_data_i  (tx_data_i[v]),
      .pld_sz_i    (tx_pkt_sz_i[v]),
      .pld_ready_o (tx_ready_o[v]),
      .link_o      (vc_link[v])
    );
  end

  vc_link_arbiter u_arbiter (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .req_i    (vc_link),
    .link_o   (send_link)
  );

  assign send_link.vc_tag = '0; // strap not used on the router side
  assign send_valid_o     = send_link.valid;
  assign send_vc_o        = send_link.vc_id;
  assign send_flit_o      = send_link.fdata;
  assign send_link.ready  = send_ready_i;

  pkt_deframer u_deframer (
    .clk_axi      (clk_axi),
    .arst_axi     (arst_axi),
    .recv_valid_i (recv_valid_i),
    .recv_vc_i    (recv_vc_i),
    .recv_flit_i  (recv_flit_i),
    .recv_ready_o (recv_ready_o),
    .rx_valid_o   (rx_valid_o),
    .rx_vc_o      (rx_vc_o),
    .rx_data_o    (rx_data_o),
    .rx_last_o    (rx_last_o),
    .rx_ready_i   (rx_ready_i),
    .frame_err_o  (frame_err_o)
  );

endmodule

// ==== bench/noc_nif_properties.sv ====
// ==========================================================
// Concurrent checks on the wormhole arbiter, bound into
// every vc_link_arbiter instance. Covers stalled request
// stability, one ready at a time, grant locking and the
// rule that every head is followed by at least one flit.
// ==========================================================
`timescale 1ns/1ns

module noc_nif_properties
  import noc_nif_pkg::*;
(
  input logic                 clk_axi,
  input logic                 arst_axi,
  input logic [NumVc-1:0]     req_valid,
  input logic [FlitWidth-1:0] req_fdata [NumVc],
  input logic [NumVc-1:0]     vc_ready,  // ready as seen by each framer
  input logic [VcIdWidth-1:0] grant,
  input logic                 lock_ff,
  input logic                 xfer,
  input flit_type_t           ftype
);

  for (genvar g = 0; g < NumVc; g++) begin : g_vc
    // stalled framer keeps its flit
    a_req_stable: assert property (@(posedge clk_axi) disable iff (arst_axi)
      req_valid[g] && !vc_ready[g] |=> req_valid[g] && $stable(req_fdata[g]))
      else $error("vc %0d request dropped or changed while stalled", g);
  end

  // one framer link moves a flit exactly when the send link does
  a_one_ready: assert property (@(posedge clk_axi) disable iff (arst_axi)
    $onehot0(vc_ready) && (xfer == |(req_valid & vc_ready)))
    else $error("framer and send link transfers disagree");

  // grant frozen from accepted head to accepted tail
  a_grant_held: assert property (@(posedge clk_axi) disable iff (arst_axi)
    (lock_ff || (xfer && ftype == HEAD_FLIT)) && !(xfer && ftype == TAIL_FLIT)
    |=> grant == $past(grant))
    else $error("grant moved inside a packet");

  // a head accepted while locked means the last head had size zero
  a_no_empty_pkt: assert property (@(posedge clk_axi) disable iff (arst_axi)
    lock_ff && xfer |-> ftype != HEAD_FLIT)
    else $error("head flit accepted inside a packet");

endmodule

// one ready bit per framer link of the NumVc links
bind vc_link_arbiter noc_nif_properties u_props (
  .clk_axi   (clk_axi),
  .arst_axi  (arst_axi),
  .req_valid (req_valid),
  .req_fdata (req_fdata),
  .vc_ready  ({req_i[1].ready, req_i[0].ready}),
  .grant     (grant),
  .lock_ff   (lock_ff),
  .xfer      (xfer),
  .ftype     (ftype)
);

// ==== bench/noc_nif_tb.sv ====
// ==========================================================
// Testbench for the NoC tile network interface. Random
// packets from an xorshift source go in on the falling
// edge, outputs are sampled just before the rising edge and
// compared with per-VC model queues and an rx state model.
// ==========================================================
`timescale 1ns/1ns

module noc_nif_tb
  import noc_nif_pkg::*;
();

  logic                                clk_axi;
  logic                                arst_axi;
  logic [NumVc-1:0]                    tx_valid_i;
  logic [NumVc-1:0][FlitDataWidth-1:0] tx_data_i;
  logic [NumVc-1:0][PktSzWidth-1:0]    tx_pkt_sz_i;
  logic [NumVc-1:0]                    tx_ready_o;
  logic                                send_valid_o;
  logic [VcIdWidth-1:0]                send_vc_o;
  logic [FlitWidth-1:0]                send_flit_o;
  logic                                send_ready_i;
  logic                                recv_valid_i;
  logic [VcIdWidth-1:0]                recv_vc_i;
  logic [FlitWidth-1:0]                recv_flit_i;
  logic                                recv_ready_o;
  logic                                rx_valid_o;
  logic [VcIdWidth-1:0]                rx_vc_o;
  logic [FlitDataWidth-1:0]            rx_data_o;
  logic                                rx_last_o;
  logic                                rx_ready_i;
  logic                                frame_err_o;

  logic [31:0] seed = 32'ha93e82bb;
  logic [PktSzWidth+FlitDataWidth-1:0] tx_stim [NumVc][$]; // {size, payload}
  logic [FlitWidth-1:0] exp_q [NumVc][$];                  // expected {type, payload}
  logic [VcIdWidth+FlitWidth-1:0] rx_stim [$];             // {vc, flit}
  rx_state_t rx_model [NumVc];
  logic [NumVc-1:0] tx_took;  // transfer seen at the last sample
  logic rx_took;
  logic err_due;               // pulse expected at the next sample
  logic pkt_open;              // send link is inside a packet
  logic [VcIdWidth-1:0] pkt_vc;
  logic tx_stall, rx_stall;
  int sent_cnt [NumVc];
  int enq_cnt [NumVc];
  int pass_cnt, fail_cnt, fails_at_start, err_seen, cycles, budget;

  noc_nif_top dut_i (.*);

  always #4 clk_axi = ~clk_axi;

  // watchdog budget grows with every queued flit
  always @(posedge clk_axi) begin
    cycles++;
    if (cycles > budget) begin
      $display("timeout: run exceeded %0d cycles for the queued flits", budget);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      fail_cnt++;
    end
    else begin
      pass_cnt++;
    end
  endtask

  task automatic add_tx_pkt(input int v, input int n);
    logic [FlitDataWidth-1:0] d;
    flit_type_t t;
    for (int i = 0; i <= n; i++) begin // head plus n flits
      d = rand32();
      if (i == 0) begin
        t = HEAD_FLIT;
      end
      else if (i == n) begin
        t = TAIL_FLIT;
      end
      else begin
        t = BODY_FLIT;
      end
      tx_stim[v].push_back({PktSzWidth'(n), d});
      exp_q[v].push_back({t, d});
      enq_cnt[v]++;
      budget += 20;
    end
  endtask

  task automatic add_rx_flit(input int v, input flit_type_t t);
    rx_stim.push_back({VcIdWidth'(v), t, rand32()});
    budget += 20;
  endtask

  task automatic add_rx_pkt(input int v, input int n);
    add_rx_flit(v, HEAD_FLIT);
    for (int i = 1; i < n; i++) begin
      add_rx_flit(v, BODY_FLIT);
    end
    add_rx_flit(v, TAIL_FLIT);
  endtask

  task automatic drive_inputs();
    for (int v = 0; v < NumVc; v++) begin
      if (tx_took[v]) begin
        void'(tx_stim[v].pop_front());
        tx_valid_i[v] = 1'b0;
      end
      if (!tx_valid_i[v] && tx_stim[v].size() > 0 && rand32() % 4 != 0) begin
        tx_valid_i[v] = 1'b1; // held until taken
        {tx_pkt_sz_i[v], tx_data_i[v]} = tx_stim[v][0];
      end
    end
    if (rx_took) begin
      void'(rx_stim.pop_front());
      recv_valid_i = 1'b0;
    end
    if (!recv_valid_i && rx_stim.size() > 0 && rand32() % 4 != 0) begin
      recv_valid_i = 1'b1;
      {recv_vc_i, recv_flit_i} = rx_stim[0];
    end
    send_ready_i = !tx_stall || (rand32() % 4 != 0); // quarter stalls
    rx_ready_i   = !rx_stall || (rand32() % 4 != 0);
  endtask

  task automatic sample_outputs();
    logic [VcIdWidth-1:0] vc;
    flit_type_t ftype;
    check_val("frame_err_o", frame_err_o, err_due);
    if (frame_err_o) begin
      err_seen++;
    end
    err_due = 1'b0;
    tx_took = tx_valid_i & tx_ready_o;
    if (!send_ready_i) begin
      check_val("tx_ready_o", tx_ready_o, '0); // stall reaches every framer
    end
    if (send_valid_o && send_ready_i) begin
      vc    = send_vc_o;
      ftype = flit_type_t'(send_flit_o[FlitWidth-1 -: 2]);
      sent_cnt[vc]++; // every accepted flit, queued or not
      if (pkt_open) begin
        check_val("send_vc_o", vc, pkt_vc); // no interleave inside a packet
      end
      if (exp_q[vc].size() == 0) begin
        $display("flit on VC %0d at %0t was never queued", vc, $time);
        fail_cnt++;
      end
      else begin
        check_val("send_flit_o", send_flit_o, exp_q[vc].pop_front());
      end
      if (ftype == HEAD_FLIT) begin
        pkt_open = 1'b1;
        pkt_vc   = vc;
      end
      else if (ftype == TAIL_FLIT) begin
        pkt_open = 1'b0;
      end
    end
    check_val("recv_ready_o", recv_ready_o, rx_ready_i);
    check_val("rx_valid_o", rx_valid_o, recv_valid_i);
    rx_took = recv_valid_i && recv_ready_o;
    ftype   = flit_type_t'(recv_flit_i[FlitWidth-1 -: 2]);
    if (recv_valid_i) begin
      check_val("rx_vc_o", rx_vc_o, recv_vc_i);
      check_val("rx_data_o", rx_data_o, recv_flit_i[FlitDataWidth-1:0]);
      check_val("rx_last_o", rx_last_o, ftype == TAIL_FLIT);
    end
    if (rx_took) begin
      if (rx_model[recv_vc_i] == RX_IDLE) begin
        err_due = (ftype != HEAD_FLIT); // body or tail with no head
      end
      else begin
        err_due = (ftype == HEAD_FLIT); // head inside a packet
      end
      rx_model[recv_vc_i] = (ftype == TAIL_FLIT) ? RX_IDLE : RX_IN_PKT;
    end
  endtask

  task automatic step();
    @(negedge clk_axi);
    drive_inputs();
    #3; // just before the rising edge
    sample_outputs();
  endtask

  function automatic bit busy();
    bit b;
    b = (rx_stim.size() != 0);
    for (int v = 0; v < NumVc; v++) begin
      if (tx_stim[v].size() != 0) begin
        b = 1'b1;
      end
    end
    return b;
  endfunction

  task automatic run_until_idle();
    do begin
      step();
    end while (busy());
    repeat (2) step(); // let a late error pulse show
  endtask

  task automatic end_test(input string name);
    for (int v = 0; v < NumVc; v++) begin
      check_val("flits left in model queue", exp_q[v].size(), 0);
      check_val("flits sent per vc", sent_cnt[v], enq_cnt[v]);
    end
    if (fail_cnt == fails_at_start) begin
      $display("test %s: passed", name);
    end
    else begin
      $display("test %s: failed", name);
    end
    fails_at_start = fail_cnt;
  endtask

  initial begin
    clk_axi      = 1'b0;
    arst_axi     = 1'b1;
    tx_valid_i   = '0;
    tx_data_i    = '0;
    tx_pkt_sz_i  = '0;
    send_ready_i = 1'b0;
    recv_valid_i = 1'b0;
    recv_vc_i    = '0;
    recv_flit_i  = '0;
    rx_ready_i   = 1'b0;
    tx_took      = '0;
    rx_took      = 1'b0;
    err_due      = 1'b0;
    pkt_open     = 1'b0;
    pkt_vc       = '0;
    tx_stall     = 1'b0;
    rx_stall     = 1'b0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    fails_at_start = 0;
    err_seen       = 0;
    cycles         = 0;
    budget         = 50; // reset and flush slack
    for (int v = 0; v < NumVc; v++) begin
      rx_model[v] = RX_IDLE;
      sent_cnt[v] = 0;
      enq_cnt[v]  = 0;
    end
    repeat (4) @(posedge clk_axi);
    @(negedge clk_axi);
    arst_axi = 1'b0;

    add_tx_pkt(0, 1 + rand32() % 15);
    run_until_idle();
    end_test("single_vc_framing");

    for (int i = 0; i < 4; i++) begin
      add_tx_pkt(0, 1 + rand32() % 15);
      add_tx_pkt(1, 1 + rand32() % 15);
    end
    run_until_idle();
    end_test("wormhole_arbitration");

    tx_stall = 1'b1;
    for (int i = 0; i < 6; i++) begin
      add_tx_pkt(0, 1 + rand32() % 15);
      add_tx_pkt(1, 1 + rand32() % 15);
    end
    run_until_idle();
    tx_stall = 1'b0;
    end_test("send_backpressure");

    rx_stall = 1'b1;
    err_seen = 0;
    for (int i = 0; i < 6; i++) begin
      add_rx_pkt(rand32() % NumVc, 1 + rand32() % 15);
    end
    run_until_idle();
    check_val("frame_err_o pulses", err_seen, 0);
    end_test("receive_path");

    err_seen = 0;
    add_rx_flit(1, BODY_FLIT); // vc 1 idle
    add_rx_flit(1, HEAD_FLIT); // vc 1 already in a packet
    add_rx_flit(1, TAIL_FLIT);
    add_rx_pkt(0, 1);
    run_until_idle();
    check_val("frame_err_o pulses", err_seen, 2);
    end_test("framing_errors");

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end
    else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== noc_nif.f ====
src/noc_nif_pkg.sv
src/flit_link_if.sv
src/pkt_framer.sv
src/vc_link_arbiter.sv
src/pkt_deframer.sv
src/noc_nif_top.sv
bench/noc_nif_properties.sv
bench/noc_nif_tb.sv

// ==== Bender.yml ====
package:
  name: noc_nif

sources:
  - src/noc_nif_pkg.sv
  - src/flit_link_if.sv
  - src/pkt_framer.sv
  - src/vc_link_arbiter.sv
  - src/pkt_deframer.sv
  - src/noc_nif_top.sv
  - target: test
    files:
      - bench/noc_nif_properties.sv
      - bench/noc_nif_tb.sv
